/* fcLayer.f */
+incdir+design
design/fcPkg.sv
design/fcCfgIf.sv
design/fcRamIf.sv
design/fcConfig.sv
design/fcBuffers.sv
design/fcSequencer.sv
design/fcMacArray.sv
design/fcLayer.sv
bench/fcLayerTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fcLayerTb \
  -f fcLayer.f --Mdir build -o fcLayerSim
./build/fcLayerSim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi

/* bench/fcLayerTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

module fcLayerTb;
  import fcPkg::*;

  localparam int timeoutCycles = 2000;

  logic                  clk;
  logic                  rstn;
  logic                  sValid;
  logic                  sReady;
  logic [`FC_DATA_W-1:0] sData;
  logic                  mValid;
  logic                  mReady;
  logic [`FC_DATA_W-1:0] mData;
  logic                  mLast;
  logic [2:0]            receiveCommand;
  logic [`FC_SIZE_W-1:0] receiveSize;
  logic                  featureDone;
  logic                  biasDone;
  logic                  fcDone;

  int          errors;
  int          checks;
  bit          stress;  // random sValid gaps and mReady stalls
  byte         featB [1024];
  byte         biasB [256];
  byte         wgt [4][1024]; // current group with row k for output 4g+k
  logic [31:0] txBuf [1024];

  fcLayer u_dut (
    .clk(clk), .rstn(rstn),
    .sValid(sValid), .sReady(sReady), .sData(sData),
    .mValid(mValid), .mReady(mReady), .mData(mData), .mLast(mLast),
    .receiveCommand(receiveCommand), .receiveSize(receiveSize),
    .featureDone(featureDone), .biasDone(biasDone), .fcDone(fcDone)
  );

  always #4 clk = ~clk;

  task automatic finishRun;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic timedOut(input string reason);
    $display("timeout: %s", reason);
    errors++;
    finishRun();
  endtask

  task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // reference lane value by dot product, shift, bias add, saturation and relu
  function automatic logic [7:0] expectedLane(input int k, input int nBytes, input int g);
    int sum;
    int val;
    sum = 0;
    for (int i = 0; i < nBytes; i++) sum = sum + int'(featB[i]) * int'(wgt[k][i]);
    val = (sum >>> `FC_SHIFT) + int'(biasB[4*g+k]);
    if (val > 127) return 8'd127;
    if (val < 0) return 8'd0;
    return val[7:0];
  endfunction

  // pushes txBuf[0..n-1] through the input stream
  task automatic sendWords(input int n);
    int idx;
    int guard;
    bit accepted;
    idx = 0;
    guard = 0;
    while (idx < n && guard < timeoutCycles) begin
      if (!sValid && (!stress || $urandom % 4 != 0)) begin
        sValid = 1'b1;
        sData  = txBuf[idx];
      end
      accepted = sValid && sReady; // transfer on the coming rising edge
      @(negedge clk);
      guard++;
      if (accepted) begin
        idx++;
        sValid = 1'b0;
      end
    end
    if (idx < n) timedOut("input stream stalled with words left to send");
  endtask

  task automatic receiveOutput(input logic [31:0] expWord, input bit isLast, input int lineWords);
    int guard;
    bit seen;
    bit taken;
    logic [31:0] heldData;
    logic heldLast;
    guard = 0;
    seen = 0;
    taken = 0;
    while (!taken && guard < timeoutCycles) begin
      if (mValid && !seen) begin
        compareValue("mValidDelay", guard, lineWords + 3);
        compareValue("mData", mData, expWord);
        compareValue("mLast", mLast, isLast);
        heldData = mData;
        heldLast = mLast;
        seen = 1;
      end else if (seen) begin
        compareValue("mValid", mValid, 1); // held until mReady
        compareValue("mData", mData, heldData); // must hold under back-pressure
        compareValue("mLast", mLast, heldLast);
      end
      mReady = stress ? ($urandom % 3 != 0) : 1'b1;
      taken = mValid && mReady;
      @(negedge clk);
      guard++;
    end
    if (!taken) timedOut("no output word was transferred");
    compareValue("sReady", sReady, !isLast); // next group opens right after the transfer
  endtask

  task automatic runLayer(input int featBytes, input int outputs, input bit bigWeights);
    int lineWords;
    int groups;
    int mag;
    logic [31:0] expWord;
    lineWords = featBytes / 4;
    groups = outputs / 4;

    for (int i = 0; i < featBytes; i++) featB[i] = byte'($urandom);
    for (int j = 0; j < lineWords; j++)
      for (int b = 0; b < 4; b++) txBuf[j][8*b +: 8] = featB[4*j+b];
    receiveSize = featBytes;
    receiveCommand = cmdFeature;
    sendWords(lineWords);
    compareValue("featureDone", featureDone, 0);
    @(negedge clk);
    compareValue("featureDone", featureDone, 1);

    for (int i = 0; i < outputs; i++) biasB[i] = byte'($urandom);
    for (int j = 0; j < groups; j++)
      for (int b = 0; b < 4; b++) txBuf[j][8*b +: 8] = biasB[4*j+b];
    receiveSize = outputs;
    receiveCommand = cmdBias;
    @(negedge clk);
    compareValue("featureDone", featureDone, 0); // cleared by the command change
    sendWords(groups);
    compareValue("biasDone", biasDone, 0);
    @(negedge clk);
    compareValue("biasDone", biasDone, 1);

    receiveCommand = cmdLayer;
    @(negedge clk);
    compareValue("biasDone", biasDone, 0);
    for (int g = 0; g < groups; g++) begin
      for (int k = 0; k < 4; k++) begin
        for (int i = 0; i < featBytes; i++) begin
          mag = 100 + $urandom % 28;
          if (!bigWeights) wgt[k][i] = byte'($urandom);
          else if (k == 0) wgt[k][i] = byte'(featB[i] < 0 ? -120 : 120); // drives lane high
          else if (k == 1) wgt[k][i] = byte'(featB[i] < 0 ? 120 : -120); // drives lane low
          else wgt[k][i] = byte'($urandom % 2 ? mag : -mag);
        end
        for (int j = 0; j < lineWords; j++)
          for (int b = 0; b < 4; b++) txBuf[k*lineWords+j][8*b +: 8] = wgt[k][4*j+b];
      end
      for (int k = 0; k < 4; k++) expWord[8*k +: 8] = expectedLane(k, featBytes, g);
      sendWords(4 * lineWords);
      receiveOutput(expWord, g == groups - 1, lineWords);
    end

    compareValue("fcDone", fcDone, 0);
    @(negedge clk);
    compareValue("fcDone", fcDone, 1);
    compareValue("mValid", mValid, 0); // no word beyond outputs/4
    receiveCommand = cmdIdle;
    @(negedge clk);
    compareValue("fcDone", fcDone, 0);
    repeat (2) @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'hf7f6));
    errors = 0;
    checks = 0;
    stress = 0;
    clk = 1'b0;
    rstn = 1'b0;
    sValid = 1'b0;
    sData = '0;
    mReady = 1'b0;
    receiveCommand = cmdIdle;
    receiveSize = '0;
    repeat (10) @(negedge clk);
    compareValue("sReady", sReady, 0);
    compareValue("mValid", mValid, 0);
    compareValue("mLast", mLast, 0);
    compareValue("featureDone", featureDone, 0);
    compareValue("biasDone", biasDone, 0);
    compareValue("fcDone", fcDone, 0);
    rstn = 1'b1;
    mReady = 1'b1;
    repeat (2) @(negedge clk);

    runLayer(16, 8, 0);
    stress = 1;
    runLayer(16, 8, 0);
    runLayer(64, 12, 1);
    finishRun();
  end

endmodule

`default_nettype wire

/* design/fcLayer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

module fcLayer (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  sValid,
  output wire                  sReady,
  input  wire [`FC_DATA_W-1:0] sData,
  output wire                  mValid,
  input  wire                  mReady,
  output wire [`FC_DATA_W-1:0] mData,
  output wire                  mLast,
  input  wire [2:0]            receiveCommand,
  input  wire [`FC_SIZE_W-1:0] receiveSize,
  output wire                  featureDone,
  output wire                  biasDone,
  output wire                  fcDone
);
  import fcPkg::*;

  fcWordT    featWord;
  fcWordT    biasWord;
  fcWeightsT weightWords;
  logic      macClear;
  logic      macAcc;
  logic      macLoad;

  fcCfgIf cfgBus ();
  fcRamIf ramBus ();

  fcConfig uConfig (
    .clk(clk), .rstn(rstn),
    .receiveCommand(fcCmdE'(receiveCommand)), .receiveSize(receiveSize),
    .cfg(cfgBus.cfg),
    .featureDone(featureDone), .biasDone(biasDone), .fcDone(fcDone)
  );

  fcBuffers uBuffers (
    .clk(clk), .ram(ramBus.ram), .sData(sData),
    .featWord(featWord), .weightWords(weightWords), .biasWord(biasWord)
  );

  fcSequencer uSequencer (
    .clk(clk), .rstn(rstn), .cfg(cfgBus.seq), .ram(ramBus.seq),
    .sValid(sValid), .sReady(sReady),
    .mValid(mValid), .mLast(mLast), .mReady(mReady),
    .macClear(macClear), .macAcc(macAcc), .macLoad(macLoad)
  );

  fcMacArray uMacArray (
    .clk(clk), .rstn(rstn),
    .macClear(macClear), .macAcc(macAcc), .macLoad(macLoad),
    .featWord(featWord), .biasWord(biasWord), .weightWords(weightWords),
    .mData(mData)
  );

endmodule

`default_nettype wire

/* design/fcMacArray.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

module fcMacArray (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire                   macClear,
  input  wire                   macAcc,
  input  wire                   macLoad,
  input  wire fcPkg::fcWordT    featWord,
  input  wire fcPkg::fcWordT    biasWord,
  input  wire fcPkg::fcWeightsT weightWords,
  output fcPkg::fcWordT         mData
);
  import fcPkg::*;

  logic signed [`FC_ACC_W-1:0] acc [4];

  // four signed byte products of one word pair
  function automatic logic signed [`FC_ACC_W-1:0] dot4(input fcWordT a, input fcWordT b);
    logic signed [15:0]          prod;
    logic signed [`FC_ACC_W-1:0] sum;
    sum = '0;
    for (int j = 0; j < 4; j++) begin
      prod = $signed(a[j]) * $signed(b[j]);
      sum  = sum + $signed({{(`FC_ACC_W-16){prod[15]}}, prod});
    end
    return sum;
  endfunction

  function automatic logic [7:0] requant(input logic signed [`FC_ACC_W-1:0] sum,
                                         input logic [7:0] bias);
    logic signed [`FC_ACC_W-1:0] val;
    val = sum >>> `FC_SHIFT;
    val = val + $signed({{(`FC_ACC_W-8){bias[7]}}, bias});
    if (val > 127) return 8'd127;
    // saturating low to -128 and then relu both end at zero
    if (val < 0) return 8'd0;
    return val[7:0];
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int k = 0; k < 4; k++) begin
        acc[k] <= '0;
      end
      mData <= '0;
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (macClear) begin
          acc[k] <= '0;
        end else if (macAcc) begin
          acc[k] <= acc[k] + dot4(featWord, weightWords[k]); // lane k = output 4g+k
        end
        if (macLoad) begin
          mData[k] <= requant(acc[k], biasWord[k]); // held through back-pressure
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/fcSequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

module fcSequencer (
  input  wire  clk,
  input  wire  rstn,
  fcCfgIf.seq  cfg,
  fcRamIf.seq  ram,
  input  wire  sValid,
  output logic sReady,
  output logic mValid,
  output logic mLast,
  input  wire  mReady,
  output logic macClear,
  output logic macAcc,
  output logic macLoad
);
  import fcPkg::*;

  fcStateE               state;
  logic [`FC_ADDR_W-1:0] wordCnt;  // word within row, also the read address
  logic [1:0]            rowCnt;
  logic [`FC_ADDR_W-1:0] groupCnt;
  logic [`FC_ADDR_W:0]   lineLast;
  logic [`FC_ADDR_W-1:0] groupLast;
  logic                  fire;
  logic                  rowEnd;
  logic                  biasLast;
  logic                  lastGroup;

  assign lineLast  = cfg.lineWords - 1'b1;
  assign groupLast = cfg.groupCount - 1'b1;
  assign rowEnd    = ({1'b0, wordCnt} == lineLast);
  assign biasLast  = (wordCnt == groupLast);
  assign lastGroup = (groupCnt == groupLast);

  assign sReady = (state == stFeatureRx) || (state == stBiasRx) || (state == stWeightRx);
  assign fire   = sValid && sReady;

  assign ram.featWr   = fire && (state == stFeatureRx);
  assign ram.biasWr   = fire && (state == stBiasRx);
  assign ram.weightWr = (fire && state == stWeightRx) ? (4'b0001 << rowCnt) : 4'b0000;
  assign ram.wrAddr   = wordCnt;
  assign ram.rdEn     = (state == stCompute);
  assign ram.rdAddr   = wordCnt;
  assign ram.biasAddr = groupCnt[$clog2(`FC_BIAS_DEPTH)-1:0];

  assign macClear = (state == stWeightRx); // accumulators idle while rows arrive
  assign macLoad  = (state == stDrain) && !macAcc;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state          <= stIdle;
      wordCnt        <= '0;
      rowCnt         <= '0;
      groupCnt       <= '0;
      macAcc         <= 1'b0;
      mValid         <= 1'b0;
      mLast          <= 1'b0;
      cfg.featureEnd <= 1'b0;
      cfg.biasEnd    <= 1'b0;
      cfg.layerEnd   <= 1'b0;
    end else begin
      macAcc         <= ram.rdEn; // RAM data lands one cycle later
      cfg.featureEnd <= 1'b0;
      cfg.biasEnd    <= 1'b0;
      cfg.layerEnd   <= 1'b0;
      case (state)
        stIdle: if (cfg.startFeature) state <= stFeatureRx;
        stFeatureRx: if (fire) begin
          wordCnt <= rowEnd ? '0 : wordCnt + 1'b1;
          if (rowEnd) begin
            cfg.featureEnd <= 1'b1;
            state          <= stFeatureWait;
          end
        end
        stFeatureWait: if (cfg.startBias) state <= stBiasRx;
        stBiasRx: if (fire) begin
          wordCnt <= biasLast ? '0 : wordCnt + 1'b1;
          if (biasLast) begin
            cfg.biasEnd <= 1'b1;
            state       <= stBiasWait;
          end
        end
        stBiasWait: if (cfg.startLayer) begin
          groupCnt <= '0;
          state    <= stWeightRx;
        end
        stWeightRx: if (fire) begin
          wordCnt <= rowEnd ? '0 : wordCnt + 1'b1;
          if (rowEnd) begin
            rowCnt <= rowCnt + 1'b1; // wraps to row 0 after the fourth
            if (rowCnt == 2'd3) state <= stCompute;
          end
        end
        stCompute: begin
          wordCnt <= rowEnd ? '0 : wordCnt + 1'b1;
          if (rowEnd) state <= stDrain;
        end
        stDrain: if (!macAcc) state <= stSend; // last product is in
        stSend: if (!mValid) begin
          mValid <= 1'b1;
          mLast  <= lastGroup;
        end else if (mReady) begin
          mValid   <= 1'b0;
          mLast    <= 1'b0;
          groupCnt <= lastGroup ? '0 : groupCnt + 1'b1;
          if (lastGroup) begin
            cfg.layerEnd <= 1'b1;
            state        <= stFinish;
          end else begin
            state <= stWeightRx;
          end
        end
        stFinish: if (cfg.clearDone) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/fcBuffers.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

module fcBuffers (
  input  wire                clk,
  fcRamIf.ram                ram,
  input  wire fcPkg::fcWordT sData,
  output fcPkg::fcWordT      featWord,
  output fcPkg::fcWeightsT   weightWords,
  output fcPkg::fcWordT      biasWord
);
  import fcPkg::*;

  fcWordT featRam [`FC_FEAT_DEPTH];
  fcWordT biasRam [`FC_BIAS_DEPTH];

  // feature line, read back once per group
  always_ff @(posedge clk) begin
    if (ram.featWr) begin
      featRam[ram.wrAddr] <= sData;
    end
    if (ram.rdEn) begin
      featWord <= featRam[ram.rdAddr];
    end
  end

  // one bias word per group of four outputs
  always_ff @(posedge clk) begin
    if (ram.biasWr) begin
      biasRam[ram.wrAddr[$clog2(`FC_BIAS_DEPTH)-1:0]] <= sData;
    end
    if (ram.rdEn) begin
      biasWord <= biasRam[ram.biasAddr]; // stays valid after rdEn drops
    end
  end

  // four row buffers, overwritten by each new group
  for (genvar r = 0; r < 4; r++) begin : gWeight
    fcWordT weightRam [`FC_FEAT_DEPTH];
    fcWordT rdWord;

    always_ff @(posedge clk) begin
      if (ram.weightWr[r]) begin
        weightRam[ram.wrAddr] <= sData;
      end
      if (ram.rdEn) begin
        rdWord <= weightRam[ram.rdAddr];
      end
    end

    assign weightWords[r] = rdWord;
  end

endmodule

`default_nettype wire

/* design/fcConfig.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

module fcConfig (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire fcPkg::fcCmdE     receiveCommand,
  input  wire [`FC_SIZE_W-1:0]  receiveSize,
  fcCfgIf.cfg                   cfg,
  output logic                  featureDone,
  output logic                  biasDone,
  output logic                  fcDone
);
  import fcPkg::*;

  fcCmdE lastCmd;
  logic  cmdChange;

  assign cmdChange = (receiveCommand != lastCmd);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lastCmd          <= cmdIdle;
      cfg.startFeature <= 1'b0;
      cfg.startBias    <= 1'b0;
      cfg.startLayer   <= 1'b0;
      cfg.clearDone    <= 1'b0;
      cfg.lineWords    <= '0;
      cfg.groupCount   <= '0;
    end else begin
      lastCmd          <= receiveCommand;
      cfg.startFeature <= cmdChange && (receiveCommand == cmdFeature);
      cfg.startBias    <= cmdChange && (receiveCommand == cmdBias);
      cfg.startLayer   <= cmdChange && (receiveCommand == cmdLayer);
      cfg.clearDone    <= cmdChange && (receiveCommand == cmdIdle);
      if (cmdChange && receiveCommand == cmdFeature) begin
        cfg.lineWords <= receiveSize[`FC_ADDR_W+2:2]; // bytes to words
      end
      if (cmdChange && receiveCommand == cmdBias) begin
        cfg.groupCount <= receiveSize[`FC_ADDR_W+1:2]; // outputs / 4
      end
    end
  end

  // level flags, any command change clears them
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      featureDone <= 1'b0;
      biasDone    <= 1'b0;
      fcDone      <= 1'b0;
    end else if (cmdChange) begin
      featureDone <= 1'b0;
      biasDone    <= 1'b0;
      fcDone      <= 1'b0;
    end else begin
      if (cfg.featureEnd) featureDone <= 1'b1;
      if (cfg.biasEnd) biasDone <= 1'b1;
      if (cfg.layerEnd) fcDone <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/fcRamIf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

interface fcRamIf;
  logic                               featWr;
  logic                               biasWr;
  logic [3:0]                         weightWr; // one hot, row within group
  logic [`FC_ADDR_W-1:0]               wrAddr;
  logic                               rdEn;
  logic [`FC_ADDR_W-1:0]               rdAddr;   // shared by feature and weights
  logic [$clog2(`FC_BIAS_DEPTH)-1:0]   biasAddr;

  modport seq (output featWr, biasWr, weightWr, wrAddr, rdEn, rdAddr, biasAddr);
  modport ram (input featWr, biasWr, weightWr, wrAddr, rdEn, rdAddr, biasAddr);
endinterface

`default_nettype wire

/* design/fcCfgIf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fc_consts.svh"

interface fcCfgIf;
  logic                 startFeature;
  logic                 startBias;
  logic                 startLayer;
  logic                 clearDone;  // command went back to idle
  logic [`FC_ADDR_W:0]   lineWords;  // words per feature line, up to 256
  logic [`FC_ADDR_W-1:0] groupCount; // groups of four outputs
  logic                 featureEnd;
  logic                 biasEnd;
  logic                 layerEnd;

  modport cfg (output startFeature, startBias, startLayer, clearDone, lineWords, groupCount,
               input featureEnd, biasEnd, layerEnd);
  modport seq (input startFeature, startBias, startLayer, clearDone, lineWords, groupCount,
               output featureEnd, biasEnd, layerEnd);
endinterface

`default_nettype wire

/* design/fcPkg.sv */
`default_nettype none
`include "fc_consts.svh"

package fcPkg;

  // host command codes
  typedef enum logic [2:0] {
    cmdIdle    = 3'd0,
    cmdFeature = 3'd1,
    cmdBias    = 3'd2,
    cmdLayer   = 3'd4
  } fcCmdE;

  typedef enum logic [3:0] {
    stIdle, stFeatureRx, stFeatureWait, stBiasRx, stBiasWait,
    stWeightRx, stCompute, stDrain, stSend, stFinish
  } fcStateE;

  typedef logic [`FC_DATA_W/8-1:0][7:0] fcWordT; // lane k in byte k
  typedef fcWordT [3:0] fcWeightsT;               // one word per weight row

endpackage

`default_nettype wire

/* design/fc_consts.svh */
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// stream and RAM word width
`define FC_DATA_W     32
`define FC_FEAT_DEPTH 256
`define FC_BIAS_DEPTH 64
`define FC_ADDR_W     8
`define FC_SIZE_W     21
`define FC_ACC_W      24
// requantize shift, applied before the bias add
`define FC_SHIFT      7

`endif
